/* rtl/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

  // Address and data width of the core.
  localparam int unsigned xlen = 32;

  // First fetch address after reset.
  localparam logic [xlen-1:0] reset_vector = 32'hbfc0_0000;

  // Size of one instruction word in bytes.
  localparam logic [xlen-1:0] pc_step = 32'd4;

  // Next-PC source, driven by execute.
  typedef enum logic [1:0] {
    pc_src_seq    = 2'd0,
    pc_src_branch = 2'd1,
    pc_src_jalr   = 2'd2
  } pc_src_e;

endpackage

`default_nettype wire

/* rtl/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

  // Field widths.
  localparam int unsigned instr_w    = 32;
  localparam int unsigned reg_addr_w = 5;
  localparam int unsigned opcode_w   = 7;
  localparam int unsigned funct3_w   = 3;

  // Field positions in the 32-bit word.
  localparam int unsigned rd_lsb       = 7;
  localparam int unsigned funct3_lsb   = 12;
  localparam int unsigned rs1_lsb      = 15;
  localparam int unsigned rs2_lsb      = 20;
  localparam int unsigned funct7_5_bit = 30;

  // Base opcodes of RV32I.
  localparam logic [opcode_w-1:0] opc_lui    = 7'b0110111;
  localparam logic [opcode_w-1:0] opc_auipc  = 7'b0010111;
  localparam logic [opcode_w-1:0] opc_jal    = 7'b1101111;
  localparam logic [opcode_w-1:0] opc_jalr   = 7'b1100111;
  localparam logic [opcode_w-1:0] opc_branch = 7'b1100011;
  localparam logic [opcode_w-1:0] opc_load   = 7'b0000011;
  localparam logic [opcode_w-1:0] opc_store  = 7'b0100011;
  localparam logic [opcode_w-1:0] opc_imm    = 7'b0010011;
  localparam logic [opcode_w-1:0] opc_reg    = 7'b0110011;
  localparam logic [opcode_w-1:0] opc_system = 7'b1110011;

  // Opcode class handed to decode.
  typedef enum logic [3:0] {
    op_lui     = 4'd0,
    op_auipc   = 4'd1,
    op_jal     = 4'd2,
    op_jalr    = 4'd3,
    op_branch  = 4'd4,
    op_load    = 4'd5,
    op_store   = 4'd6,
    op_imm     = 4'd7,
    op_reg     = 4'd8,
    op_system  = 4'd9,
    op_illegal = 4'd10
  } op_class_e;

endpackage

`default_nettype wire

/* rtl/pc_gen.sv */
`default_nettype none

module pc_gen (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      pc_en_i,
  input  logic                      imem_ready_i,
  input  fetch_pkg::pc_src_e        pc_src_i,
  input  logic [fetch_pkg::xlen-1:0] branch_target_i,
  input  logic [fetch_pkg::xlen-1:0] jalr_target_i,
  input  logic                      store_pend_i,
  input  logic                      store_ex_i,
  input  logic                      dmem_ready_i,
  input  logic [fetch_pkg::xlen-1:0] store_addr_i,
  input  logic [fetch_pkg::xlen-1:0] store_addr_ex_i,
  output logic [fetch_pkg::xlen-1:0] pc_o,
  output logic [fetch_pkg::xlen-1:0] pc_plus4_o,
  output logic                      fetch_hold_o
);

  import fetch_pkg::*;

  logic [xlen-1:0] pc_q;
  logic [xlen-1:0] pc_plus4;
  logic [xlen-1:0] pc_next;
  logic [xlen-1:0] jalr_aligned;
  logic            store_hits_pc;
  logic            store_in_flight;
  logic            fetch_hold;
  logic            pc_load;

  assign pc_plus4 = pc_q + pc_step;

  // jalr clears the low bit of the target.
  assign jalr_aligned = {jalr_target_i[xlen-1:1], 1'b0};

  always_comb begin
    case (pc_src_i)
      pc_src_seq: begin
        pc_next = pc_plus4;
      end
      pc_src_branch: begin
        pc_next = branch_target_i;
      end
      pc_src_jalr: begin
        pc_next = jalr_aligned;
      end
      default: begin
        pc_next = pc_plus4;
      end
    endcase
  end

  // An older store still targets the word at the current PC.
  assign store_hits_pc = store_pend_i && (store_addr_i == pc_q);

  // Execute writes that same address this cycle.
  assign store_in_flight = store_ex_i && dmem_ready_i &&
                           (store_addr_ex_i == store_addr_i);

  // Freeze fetch until the new data is in memory.
  assign fetch_hold = store_hits_pc && !store_in_flight;

  assign pc_load = pc_en_i && imem_ready_i && !fetch_hold;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pc_q <= reset_vector;
    end else if (pc_load) begin
      pc_q <= pc_next;
    end
  end

  assign pc_o         = pc_q;
  assign pc_plus4_o   = pc_plus4;
  assign fetch_hold_o = fetch_hold;

endmodule

`default_nettype wire

/* rtl/if_id_reg.sv */
`default_nettype none

module if_id_reg (
  input  logic                                   clk_i,
  input  logic                                   reset_i,
  input  logic                                   if_id_en_i,
  input  logic                                   flush_i,
  input  logic                                   fetch_hold_i,
  input  logic [fetch_pkg::xlen-1:0]             pc_i,
  input  logic [fetch_pkg::xlen-1:0]             pc_plus4_i,
  input  logic [rv_isa_pkg::instr_w-1:0]         instr_i,
  output logic                                   valid_o,
  output logic [fetch_pkg::xlen-1:0]             pc_o,
  output logic [fetch_pkg::xlen-1:0]             pc_plus4_o,
  output logic [rv_isa_pkg::reg_addr_w-1:0]      rs1_o,
  output logic [rv_isa_pkg::reg_addr_w-1:0]      rs2_o,
  output logic [rv_isa_pkg::reg_addr_w-1:0]      rd_o,
  output logic [rv_isa_pkg::opcode_w-1:0]        opcode_o,
  output logic [rv_isa_pkg::funct3_w-1:0]        funct3_o,
  output logic                                   funct7_5_o,
  output logic [rv_isa_pkg::instr_w-1:rv_isa_pkg::rd_lsb] instr_hi_o,
  output rv_isa_pkg::op_class_e                  op_class_o
);

  import fetch_pkg::*;
  import rv_isa_pkg::*;

  logic                  valid_q;
  logic [xlen-1:0]       pc_q;
  logic [xlen-1:0]       pc_plus4_q;
  logic [instr_w-1:0]    instr_q;
  logic [opcode_w-1:0]   opcode;
  logic                  load;
  op_class_e             op_class;

  assign load = if_id_en_i && !fetch_hold_i;

  // Flush empties the stage even when a load is requested.
  always_ff @(posedge clk_i) begin
    if (reset_i || flush_i) begin
      valid_q    <= 1'b0;
      pc_q       <= '0;
      pc_plus4_q <= '0;
      instr_q    <= '0;
    end else if (load) begin
      valid_q    <= 1'b1;
      pc_q       <= pc_i;
      pc_plus4_q <= pc_plus4_i;
      instr_q    <= instr_i;
    end
  end

  // Field split of the held word.
  assign opcode     = instr_q[opcode_w-1:0];
  assign rd_o       = instr_q[rd_lsb +: reg_addr_w];
  assign funct3_o   = instr_q[funct3_lsb +: funct3_w];
  assign rs1_o      = instr_q[rs1_lsb +: reg_addr_w];
  assign rs2_o      = instr_q[rs2_lsb +: reg_addr_w];
  assign funct7_5_o = instr_q[funct7_5_bit];
  assign instr_hi_o = instr_q[instr_w-1:rd_lsb];

  // A cleared word has opcode zero, which lands in op_illegal.
  always_comb begin
    case (opcode)
      opc_lui: begin
        op_class = op_lui;
      end
      opc_auipc: begin
        op_class = op_auipc;
      end
      opc_jal: begin
        op_class = op_jal;
      end
      opc_jalr: begin
        op_class = op_jalr;
      end
      opc_branch: begin
        op_class = op_branch;
      end
      opc_load: begin
        op_class = op_load;
      end
      opc_store: begin
        op_class = op_store;
      end
      opc_imm: begin
        op_class = op_imm;
      end
      opc_reg: begin
        op_class = op_reg;
      end
      opc_system: begin
        op_class = op_system;
      end
      default: begin
        op_class = op_illegal;
      end
    endcase
  end

  assign valid_o    = valid_q;
  assign pc_o       = pc_q;
  assign pc_plus4_o = pc_plus4_q;
  assign opcode_o   = opcode;
  assign op_class_o = op_class;

endmodule

`default_nettype wire

/* rtl/fetch_stage.sv */
`default_nettype none

module fetch_stage (
  input  logic                                   clk_i,
  input  logic                                   reset_i,
  input  logic                                   pc_en_i,
  input  logic                                   if_id_en_i,
  input  logic                                   flush_i,
  input  fetch_pkg::pc_src_e                     pc_src_i,
  input  logic [fetch_pkg::xlen-1:0]             branch_target_i,
  input  logic [fetch_pkg::xlen-1:0]             jalr_target_i,
  input  logic                                   imem_ready_i,
  input  logic [rv_isa_pkg::instr_w-1:0]         imem_instr_i,
  input  logic                                   store_pend_i,
  input  logic [fetch_pkg::xlen-1:0]             store_addr_i,
  input  logic                                   store_ex_i,
  input  logic [fetch_pkg::xlen-1:0]             store_addr_ex_i,
  input  logic                                   dmem_ready_i,
  output logic [fetch_pkg::xlen-1:0]             imem_addr_o,
  output logic                                   id_valid_o,
  output logic [fetch_pkg::xlen-1:0]             id_pc_o,
  output logic [fetch_pkg::xlen-1:0]             id_pc_plus4_o,
  output logic [rv_isa_pkg::reg_addr_w-1:0]      id_rs1_o,
  output logic [rv_isa_pkg::reg_addr_w-1:0]      id_rs2_o,
  output logic [rv_isa_pkg::reg_addr_w-1:0]      id_rd_o,
  output logic [rv_isa_pkg::opcode_w-1:0]        id_opcode_o,
  output logic [rv_isa_pkg::funct3_w-1:0]        id_funct3_o,
  output logic                                   id_funct7_5_o,
  output logic [rv_isa_pkg::instr_w-1:rv_isa_pkg::rd_lsb] id_instr_hi_o,
  output rv_isa_pkg::op_class_e                  id_op_class_o
);

  import fetch_pkg::*;

  logic [xlen-1:0] pc;
  logic [xlen-1:0] pc_plus4;
  logic            fetch_hold;

  pc_gen u_pc_gen (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .pc_en_i         (pc_en_i),
    .imem_ready_i    (imem_ready_i),
    .pc_src_i        (pc_src_i),
    .branch_target_i (branch_target_i),
    .jalr_target_i   (jalr_target_i),
    .store_pend_i    (store_pend_i),
    .store_ex_i      (store_ex_i),
    .dmem_ready_i    (dmem_ready_i),
    .store_addr_i    (store_addr_i),
    .store_addr_ex_i (store_addr_ex_i),
    .pc_o            (pc),
    .pc_plus4_o      (pc_plus4),
    .fetch_hold_o    (fetch_hold)
  );

  // The PC register drives the instruction memory directly.
  assign imem_addr_o = pc;

  if_id_reg u_if_id_reg (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .if_id_en_i   (if_id_en_i),
    .flush_i      (flush_i),
    .fetch_hold_i (fetch_hold),
    .pc_i         (pc),
    .pc_plus4_i   (pc_plus4),
    .instr_i      (imem_instr_i),
    .valid_o      (id_valid_o),
    .pc_o         (id_pc_o),
    .pc_plus4_o   (id_pc_plus4_o),
    .rs1_o        (id_rs1_o),
    .rs2_o        (id_rs2_o),
    .rd_o         (id_rd_o),
    .opcode_o     (id_opcode_o),
    .funct3_o     (id_funct3_o),
    .funct7_5_o   (id_funct7_5_o),
    .instr_hi_o   (id_instr_hi_o),
    .op_class_o   (id_op_class_o)
  );

endmodule

`default_nettype wire

/* test/fetch_checker.sv */
`default_nettype none

module fetch_checker (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  logic                            check_en_i,
  input  logic [fetch_pkg::xlen-1:0]      exp_pc_i,
  input  logic [fetch_pkg::xlen-1:0]      exp_id_pc_i,
  input  logic                            if_id_en_i,
  input  logic                            flush_i,
  input  logic [31:0]                     imem_instr_i,
  input  logic                            store_pend_i,
  input  logic [fetch_pkg::xlen-1:0]      store_addr_i,
  input  logic                            store_ex_i,
  input  logic [fetch_pkg::xlen-1:0]      store_addr_ex_i,
  input  logic                            dmem_ready_i,
  input  logic [fetch_pkg::xlen-1:0]      imem_addr_i,
  input  logic                            id_valid_i,
  input  logic [fetch_pkg::xlen-1:0]      id_pc_i,
  input  logic [fetch_pkg::xlen-1:0]      id_pc_plus4_i,
  input  logic [4:0]                      id_rs1_i,
  input  logic [4:0]                      id_rs2_i,
  input  logic [4:0]                      id_rd_i,
  input  logic [6:0]                      id_opcode_i,
  input  logic [2:0]                      id_funct3_i,
  input  logic                            id_funct7_5_i,
  input  logic [31:7]                     id_instr_hi_i,
  input  rv_isa_pkg::op_class_e           id_op_class_i,
  output int                              errors_o,
  output int                              lines_done_o
);

  import fetch_pkg::*;
  import rv_isa_pkg::*;

  int              errors = 0;
  int              lines_done = 0;
  logic            started = 1'b0;
  logic            rst_q = 1'b0;
  logic            chk_q = 1'b0;
  logic [xlen-1:0] exp_pc_q;
  logic [xlen-1:0] exp_id_pc_q;
  logic            ref_valid;
  logic [xlen-1:0] ref_pc;
  logic [31:0]     ref_instr;
  logic            hold;

  // Opcode values as listed in the RV32I base opcode map.
  function automatic op_class_e class_of(input logic [6:0] opc);
    case (opc)
      7'b0110111: return op_lui;
      7'b0010111: return op_auipc;
      7'b1101111: return op_jal;
      7'b1100111: return op_jalr;
      7'b1100011: return op_branch;
      7'b0000011: return op_load;
      7'b0100011: return op_store;
      7'b0010011: return op_imm;
      7'b0110011: return op_reg;
      7'b1110011: return op_system;
      default:    return op_illegal;
    endcase
  endfunction

  task automatic compare(input string what, input logic [xlen-1:0] got,
                         input logic [xlen-1:0] exp);
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // Older store to the fetch word that execute is not writing right now.
  assign hold = store_pend_i && (store_addr_i == imem_addr_i) &&
                !(store_ex_i && dmem_ready_i && (store_addr_ex_i == store_addr_i));

  always @(posedge clk_i) begin
    rst_q       <= reset_i;
    chk_q       <= check_en_i;
    exp_pc_q    <= exp_pc_i;
    exp_id_pc_q <= exp_id_pc_i;
    if (reset_i) begin
      started <= 1'b1;
    end
    if (reset_i || flush_i) begin
      ref_valid <= 1'b0;
      ref_pc    <= '0;
      ref_instr <= '0;
    end else if (if_id_en_i && !hold) begin
      ref_valid <= 1'b1;
      ref_pc    <= imem_addr_i;
      ref_instr <= imem_instr_i;
    end
  end

  always @(negedge clk_i) begin
    if (started) begin
      if (rst_q) begin
        compare("imem_addr_o after reset", imem_addr_i, reset_vector);
      end
      if (chk_q) begin
        compare("imem_addr_o", imem_addr_i, exp_pc_q);
        compare("id_pc_o against file", id_pc_i, exp_id_pc_q);
        lines_done++;
      end
      compare("id_valid_o", id_valid_i, ref_valid);
      compare("id_pc_o", id_pc_i, ref_pc);
      compare("id_pc_plus4_o", id_pc_plus4_i, ref_valid ? ref_pc + 32'd4 : 32'd0);
      compare("id_rd_o", id_rd_i, ref_instr[11:7]);
      compare("id_rs1_o", id_rs1_i, ref_instr[19:15]);
      compare("id_rs2_o", id_rs2_i, ref_instr[24:20]);
      compare("id_opcode_o", id_opcode_i, ref_instr[6:0]);
      compare("id_funct3_o", id_funct3_i, ref_instr[14:12]);
      compare("id_funct7_5_o", id_funct7_5_i, ref_instr[30]);
      compare("id_instr_hi_o", id_instr_hi_i, ref_instr[31:7]);
      compare("id_op_class_o", id_op_class_i, class_of(ref_instr[6:0]));
    end
  end

  assign errors_o     = errors;
  assign lines_done_o = lines_done;

endmodule

`default_nettype wire

/* test/fetch_stage_tb.sv */
`default_nettype none

module fetch_stage_tb;

  import fetch_pkg::*;
  import rv_isa_pkg::*;

  typedef struct packed {
    logic            pc_en;
    logic            id_en;
    logic            flush;
    logic [1:0]      src;
    logic [xlen-1:0] branch;
    logic [xlen-1:0] jalr;
    logic            ready;
    logic            spend;
    logic [xlen-1:0] saddr;
    logic            sex;
    logic [xlen-1:0] saddr_ex;
    logic            dmrdy;
    logic [31:0]     instr;
    logic [xlen-1:0] exp_pc;
    logic [xlen-1:0] exp_id_pc;
  } stim_t;

  localparam string test_file = "test/fetch_stage_tests.txt";
  localparam int    max_wait  = 40;

  logic            clk;
  logic            reset;
  logic            pc_en;
  logic            if_id_en;
  logic            flush;
  pc_src_e         pc_src;
  logic [xlen-1:0] branch_target;
  logic [xlen-1:0] jalr_target;
  logic            imem_ready;
  logic [31:0]     imem_instr;
  logic            store_pend;
  logic [xlen-1:0] store_addr;
  logic            store_ex;
  logic [xlen-1:0] store_addr_ex;
  logic            dmem_ready;
  logic [xlen-1:0] imem_addr;
  logic            id_valid;
  logic [xlen-1:0] id_pc;
  logic [xlen-1:0] id_pc_plus4;
  logic [4:0]      id_rs1;
  logic [4:0]      id_rs2;
  logic [4:0]      id_rd;
  logic [6:0]      id_opcode;
  logic [2:0]      id_funct3;
  logic            id_funct7_5;
  logic [31:7]     id_instr_hi;
  op_class_e       id_op_class;
  logic            check_en;
  logic [xlen-1:0] exp_pc;
  logic [xlen-1:0] exp_id_pc;
  int              errors;
  int              lines_done;
  int              seed = 12806;
  logic            failed;
  stim_t           tests[$];

  fetch_stage uut (
    .clk_i(clk), .reset_i(reset), .pc_en_i(pc_en), .if_id_en_i(if_id_en),
    .flush_i(flush), .pc_src_i(pc_src), .branch_target_i(branch_target),
    .jalr_target_i(jalr_target), .imem_ready_i(imem_ready), .imem_instr_i(imem_instr),
    .store_pend_i(store_pend), .store_addr_i(store_addr), .store_ex_i(store_ex),
    .store_addr_ex_i(store_addr_ex), .dmem_ready_i(dmem_ready), .imem_addr_o(imem_addr),
    .id_valid_o(id_valid), .id_pc_o(id_pc), .id_pc_plus4_o(id_pc_plus4),
    .id_rs1_o(id_rs1), .id_rs2_o(id_rs2), .id_rd_o(id_rd), .id_opcode_o(id_opcode),
    .id_funct3_o(id_funct3), .id_funct7_5_o(id_funct7_5), .id_instr_hi_o(id_instr_hi),
    .id_op_class_o(id_op_class)
  );

  fetch_checker u_checker (
    .clk_i(clk), .reset_i(reset), .check_en_i(check_en), .exp_pc_i(exp_pc),
    .exp_id_pc_i(exp_id_pc), .if_id_en_i(if_id_en), .flush_i(flush),
    .imem_instr_i(imem_instr), .store_pend_i(store_pend), .store_addr_i(store_addr),
    .store_ex_i(store_ex), .store_addr_ex_i(store_addr_ex), .dmem_ready_i(dmem_ready),
    .imem_addr_i(imem_addr), .id_valid_i(id_valid), .id_pc_i(id_pc),
    .id_pc_plus4_i(id_pc_plus4), .id_rs1_i(id_rs1), .id_rs2_i(id_rs2), .id_rd_i(id_rd),
    .id_opcode_i(id_opcode), .id_funct3_i(id_funct3), .id_funct7_5_i(id_funct7_5),
    .id_instr_hi_i(id_instr_hi), .id_op_class_i(id_op_class), .errors_o(errors),
    .lines_done_o(lines_done)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #4 clk = ~clk;
    end
  end

  task automatic read_tests(output bit ok);
    int          fd;
    int          n;
    string       line;
    logic [31:0] f [15];
    ok = 1'b1;
    fd = $fopen(test_file, "r");
    if (fd == 0) begin
      $display("could not open the test data file %s", test_file);
      ok = 1'b0;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (line.len() < 2 || line.substr(0, 0) == "#") begin
        continue;
      end
      n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                  f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                  f[8], f[9], f[10], f[11], f[12], f[13], f[14]);
      if (n != 15) begin
        $display("test data line has %0d of 15 columns: %s", n, line);
        ok = 1'b0;
        continue;
      end
      tests.push_back({f[0][0], f[1][0], f[2][0], f[3][1:0], f[4], f[5], f[6][0],
                       f[7][0], f[8], f[9][0], f[10], f[11][0], f[12], f[13], f[14]});
    end
    $fclose(fd);
  endtask

  task automatic drive(input stim_t s);
    pc_en         <= s.pc_en;
    if_id_en      <= s.id_en;
    flush         <= s.flush;
    pc_src        <= pc_src_e'(s.src);
    branch_target <= s.branch;
    jalr_target   <= s.jalr;
    imem_ready    <= s.ready;
    store_pend    <= s.spend;
    store_addr    <= s.saddr;
    store_ex      <= s.sex;
    store_addr_ex <= s.saddr_ex;
    dmem_ready    <= s.dmrdy;
    // A zero word in the file asks for a random one.
    imem_instr    <= (s.instr == 32'd0) ? $random(seed) : s.instr;
    exp_pc        <= s.exp_pc;
    exp_id_pc     <= s.exp_id_pc;
    check_en      <= 1'b1;
  endtask

  task automatic go_idle();
    pc_en      <= 1'b0;
    if_id_en   <= 1'b0;
    flush      <= 1'b0;
    store_pend <= 1'b0;
    store_ex   <= 1'b0;
    check_en   <= 1'b0;
  endtask

  task automatic wait_reset_vector(output bit ok);
    int n;
    ok = 1'b0;
    n = 0;
    while (!ok && n < max_wait) begin
      @(negedge clk);
      ok = (imem_addr === reset_vector);
      n++;
    end
  endtask

  task automatic wait_checks_done(input int target, output bit ok);
    int n;
    ok = 1'b0;
    n = 0;
    while (!ok && n < max_wait) begin
      @(posedge clk);
      ok = (lines_done >= target);
      n++;
    end
  endtask

  initial begin
    bit ok;
    failed        = 1'b0;
    reset         = 1'b1;
    pc_en         = 1'b0;
    if_id_en      = 1'b0;
    flush         = 1'b0;
    pc_src        = pc_src_seq;
    branch_target = '0;
    jalr_target   = '0;
    imem_ready    = 1'b0;
    imem_instr    = '0;
    store_pend    = 1'b0;
    store_addr    = '0;
    store_ex      = 1'b0;
    store_addr_ex = '0;
    dmem_ready    = 1'b0;
    check_en      = 1'b0;
    exp_pc        = '0;
    exp_id_pc     = '0;
    read_tests(ok);
    failed = !ok || tests.size() == 0;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    if (!failed) begin
      wait_reset_vector(ok);
      if (!ok) begin
        $display("timeout: imem_addr_o never showed the reset vector after reset");
        failed = 1'b1;
      end
    end
    if (!failed) begin
      foreach (tests[i]) begin
        @(posedge clk);
        drive(tests[i]);
      end
      @(posedge clk);
      go_idle();
      wait_checks_done(tests.size(), ok);
      if (!ok) begin
        $display("timeout: only %0d of %0d test lines were compared", lines_done,
                 tests.size());
        failed = 1'b1;
      end
    end
    $display("test lines %0d, compared %0d, errors %0d", tests.size(), lines_done, errors);
    if (failed || errors != 0) begin
      $display("tests failed");
    end else begin
      $display("all tests passed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* rv_fetch.f */
rtl/fetch_pkg.sv
rtl/rv_isa_pkg.sv
rtl/pc_gen.sv
rtl/if_id_reg.sv
rtl/fetch_stage.sv
test/fetch_checker.sv
test/fetch_stage_tb.sv

/* Bender.yml */
package:
  name: rv_fetch

sources:
  - files:
      - rtl/fetch_pkg.sv
      - rtl/rv_isa_pkg.sv
      - rtl/pc_gen.sv
      - rtl/if_id_reg.sv
      - rtl/fetch_stage.sv
  - target: test
    files:
      - test/fetch_checker.sv
      - test/fetch_stage_tb.sv

/* test/fetch_stage_tests.txt */
# pc_en if_id_en flush pc_src branch_target jalr_target imem_ready store_pend store_addr
# store_ex store_addr_ex dmem_ready instr(0 = random) exp_imem_addr exp_id_pc
1 1 0 0 00000000 00000000 1 0 00000000 0 00000000 0 00500093 bfc00004 bfc00000
1 1 0 0 00000000 00000000 1 0 00000000 0 00000000 0 12345137 bfc00008 bfc00004
1 1 0 0 00000000 00000000 1 0 00000000 0 00000000 0 002081b3 bfc0000c bfc00008
0 1 0 0 00000000 00000000 1 0 00000000 0 00000000 0 40118233 bfc0000c bfc0000c
1 0 0 0 00000000 00000000 0 0 00000000 0 00000000 0 0080a283 bfc0000c bfc0000c
1 1 0 1 80001000 00000000 1 0 00000000 0 00000000 0 0080a283 80001000 bfc0000c
1 1 0 2 00000000 80002001 1 0 00000000 0 00000000 0 0050a623 80002000 80001000
1 1 0 0 00000000 00000000 1 1 80002000 0 00000000 0 00208463 80002000 80001000
1 1 0 0 00000000 00000000 1 1 80002000 1 80002000 0 00208463 80002000 80001000
1 1 0 0 00000000 00000000 1 1 80002000 1 80002000 1 008000ef 80002004 80002000
1 1 0 0 00000000 00000000 1 1 80002004 1 80003000 1 008000ef 80002004 80002000
1 1 0 0 00000000 00000000 1 1 90000000 0 00000000 0 00008067 80002008 80002004
1 1 1 0 00000000 00000000 1 0 00000000 0 00000000 0 00001317 8000200c 00000000
1 1 0 0 00000000 00000000 1 0 00000000 0 00000000 0 00000000 80002010 8000200c
1 1 0 0 00000000 00000000 1 0 00000000 0 00000000 0 00000000 80002014 80002010
1 1 0 0 00000000 00000000 1 0 00000000 0 00000000 0 00000073 80002018 80002014
1 1 0 0 00000000 00000000 1 0 00000000 0 00000000 0 ffffffff 8000201c 80002018
1 0 1 0 00000000 00000000 1 0 00000000 0 00000000 0 00001317 80002020 00000000
1 1 0 0 00000000 00000000 1 0 00000000 0 00000000 0 00001317 80002024 80002020
